/* hw/battleCfg.svh */
`ifndef BATTLE_CFG_SVH
`define BATTLE_CFG_SVH

// clk cycles per game second, kept short for simulation
`define TICK_CYCLES 16

// page time limits in game seconds
`define MENU_SECONDS 3
`define DODGE_SECONDS 7
`define CHECK_SECONDS 3

// monster and player numbers
`define KILL_HP 100
`define HEAL_AMOUNT 10
`define START_HP 100

`endif

/* hw/battlePkg.sv */
package battlePkg;

    // page codes as shown in the upper nibble of the game state
    typedef enum logic [3:0] {
        PAGE_NULL   = 4'h0,
        PAGE_MENU   = 4'h1,
        PAGE_DODGE  = 4'h9,
        PAGE_ATTACK = 4'hA,
        PAGE_ACTION = 4'hB,
        PAGE_CHECK  = 4'hC
    } pageT;

    typedef enum logic [3:0] {
        KEY_NONE, KEY_W, KEY_A, KEY_S, KEY_D, KEY_J, KEY_K, KEY_L, KEY_SPACE
    } keyT;

    // opcodes in the top nibble of the player instruction
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_HPY = 4'h1,
        OP_DPY = 4'h2,
        OP_MOV = 4'h5,
        OP_SHP = 4'h6
    } opcodeT;

    typedef enum logic [7:0] {
        DIR_UP    = 8'h00,
        DIR_LEFT  = 8'h01,
        DIR_DOWN  = 8'h02,
        DIR_RIGHT = 8'h03
    } dirT;

    // controller requests to the instruction encoder
    typedef enum logic [2:0] {
        CMD_NONE, CMD_MOVE, CMD_HURT, CMD_HEAL, CMD_SETHP
    } cmdKindT;

endpackage

/* hw/keyDecoder.sv */
`timescale 1ns/100ps

module keyDecoder import battlePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] keyboard,
    output keyT        key,
    output logic       keyPress
);

    logic [7:0] scanCode;
    keyT        prevKey;

    // PS/2 set 2 make codes of the keys the game listens to
    always_comb begin
        case (scanCode)
            8'h1D:   key = KEY_W;
            8'h1C:   key = KEY_A;
            8'h1B:   key = KEY_S;
            8'h23:   key = KEY_D;
            8'h3B:   key = KEY_J;
            8'h42:   key = KEY_K;
            8'h4B:   key = KEY_L;
            8'h29:   key = KEY_SPACE;
            default: key = KEY_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scanCode <= '0;
            prevKey  <= KEY_NONE;
        end else begin
            scanCode <= keyboard;
            prevKey  <= key;
        end
    end

    // a held key gives one pulse only
    assign keyPress = (key != KEY_NONE) && (key != prevKey);

    singlePress: assert property (@(posedge clk) disable iff (!rstN)
        keyPress |-> (key != KEY_NONE) ##1 (!keyPress || $changed(key)));

endmodule

/* hw/secondTimer.sv */
`timescale 1ns/100ps
`include "battleCfg.svh"

module secondTimer (
    input  logic       clk,
    input  logic       rstN,
    input  logic       pageEntry,
    output logic [3:0] seconds
);

    localparam int DivW = ($clog2(`TICK_CYCLES) > 0) ? $clog2(`TICK_CYCLES) : 1;

    logic [DivW-1:0] divCnt;
    logic            tick;

    // last cycle of a game second
    assign tick = (divCnt == DivW'(`TICK_CYCLES - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divCnt  <= '0;
            seconds <= '0;
        end else if (pageEntry) begin
            // every page counts from its own entry
            divCnt  <= '0;
            seconds <= '0;
        end else begin
            if (tick) begin
                divCnt <= '0;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
            // stick at 15 on long pages
            if (tick && (seconds != 4'hF)) begin
                seconds <= seconds + 1'b1;
            end
        end
    end

endmodule

/* hw/battleControl.sv */
`timescale 1ns/100ps
`include "battleCfg.svh"

module battleControl import battlePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  keyT        key,
    input  logic       keyPress,
    input  logic [3:0] seconds,
    input  logic       isDeath,
    input  logic       isDmgComplete,
    input  logic       heal,
    input  logic [7:0] damage,
    input  logic       atkPass,
    input  logic       wouldDefeat,
    output pageT       page,
    output logic       pageEntry,
    output cmdKindT    cmdKind,
    output dirT        cmdDir,
    output logic [7:0] cmdValue,
    output logic       startDmg,
    output logic       hpClear,
    output logic       hpAdd,
    output logic       atkStart,
    output logic       atkButton,
    output logic       atkReset,
    output logic       bulletRun
);

    pageT pageNext;
    logic mercy;
    logic mercyNext;
    logic startDmgNext;
    logic atkStartNext;
    logic atkButtonNext;
    logic atkResetNext;
    logic bulletRunNext;
    logic hitSpace;
    logic hitJ;
    logic hitK;
    logic hitL;

    // fresh presses only
    assign hitSpace = keyPress && (key == KEY_SPACE);
    assign hitJ     = keyPress && (key == KEY_J);
    assign hitK     = keyPress && (key == KEY_K);
    assign hitL     = keyPress && (key == KEY_L);

    // timer restarts on the edge that moves the page
    assign pageEntry = (pageNext != page);

    ////////////////////
    // page rules
    ////////////////////
    always_comb begin
        pageNext      = page;
        mercyNext     = mercy;
        startDmgNext  = 1'b0;
        atkStartNext  = atkStart;
        atkButtonNext = atkButton;
        atkResetNext  = atkReset;
        bulletRunNext = bulletRun;
        cmdKind       = CMD_NONE;
        cmdDir        = DIR_UP;
        cmdValue      = '0;
        hpClear       = 1'b0;
        hpAdd         = 1'b0;
        case (page)
            PAGE_MENU: begin
                if (hitSpace && (seconds >= 4'(`MENU_SECONDS))) begin
                    pageNext      = PAGE_DODGE;
                    cmdKind       = CMD_SETHP;
                    cmdValue      = 8'(`START_HP);
                    hpClear       = 1'b1;
                    mercyNext     = 1'b0;
                    atkStartNext  = 1'b0;
                    atkButtonNext = 1'b0;
                    atkResetNext  = 1'b1;
                    bulletRunNext = 1'b1;
                end
            end
            PAGE_DODGE: begin
                if (seconds >= 4'(`DODGE_SECONDS)) begin
                    pageNext      = PAGE_ACTION;
                    bulletRunNext = 1'b0;
                end else if (isDeath) begin
                    pageNext      = PAGE_MENU;
                    bulletRunNext = 1'b0;
                end else if (isDmgComplete) begin
                    if (heal) begin
                        cmdKind = CMD_HEAL;
                    end else begin
                        cmdKind = CMD_HURT;
                    end
                    cmdValue     = damage;
                    startDmgNext = 1'b1;
                end else if (keyPress) begin
                    cmdKind = CMD_MOVE;
                    case (key)
                        KEY_W:   cmdDir = DIR_UP;
                        KEY_A:   cmdDir = DIR_LEFT;
                        KEY_S:   cmdDir = DIR_DOWN;
                        KEY_D:   cmdDir = DIR_RIGHT;
                        default: cmdKind = CMD_NONE;
                    endcase
                end
            end
            PAGE_ACTION: begin
                if (hitJ) begin
                    pageNext      = PAGE_ATTACK;
                    atkStartNext  = 1'b1;
                    atkResetNext  = 1'b0;
                    atkButtonNext = 1'b0;
                end else if (hitK) begin
                    pageNext = PAGE_CHECK;
                end else if (hitL) begin
                    // spared monster ends the game
                    if (mercy) begin
                        pageNext = PAGE_MENU;
                    end else begin
                        pageNext      = PAGE_DODGE;
                        bulletRunNext = 1'b1;
                    end
                end
            end
            PAGE_CHECK: begin
                if ((seconds >= 4'(`CHECK_SECONDS)) && (hitJ || hitK || hitL)) begin
                    pageNext      = PAGE_DODGE;
                    bulletRunNext = 1'b1;
                    if (hitJ) begin
                        mercyNext = 1'b1;
                    end
                end
            end
            PAGE_ATTACK: begin
                if (atkPass) begin
                    hpAdd         = 1'b1;
                    atkStartNext  = 1'b0;
                    atkButtonNext = 1'b0;
                    atkResetNext  = 1'b1;
                    // look-ahead total decides the exit in this cycle
                    if (wouldDefeat) begin
                        pageNext = PAGE_MENU;
                    end else begin
                        pageNext      = PAGE_DODGE;
                        bulletRunNext = 1'b1;
                    end
                end else if (hitSpace) begin
                    atkButtonNext = 1'b1;
                end
            end
            default: begin
                pageNext      = PAGE_MENU;
                bulletRunNext = 1'b0;
            end
        endcase
    end

    ////////////////////
    // state registers
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            page      <= PAGE_MENU;
            mercy     <= 1'b0;
            startDmg  <= 1'b0;
            atkStart  <= 1'b0;
            atkButton <= 1'b0;
            atkReset  <= 1'b1;
            bulletRun <= 1'b0;
        end else begin
            page      <= pageNext;
            mercy     <= mercyNext;
            startDmg  <= startDmgNext;
            atkStart  <= atkStartNext;
            atkButton <= atkButtonNext;
            atkReset  <= atkResetNext;
            bulletRun <= bulletRunNext;
        end
    end

    entryMovesPage: assert property (@(posedge clk) disable iff (!rstN)
        pageEntry |=> $changed(page));

    atkStartInAttack: assert property (@(posedge clk) disable iff (!rstN)
        atkStart |-> (page == PAGE_ATTACK));

endmodule

/* hw/playerCommand.sv */
`timescale 1ns/100ps
`include "battleCfg.svh"

module playerCommand import battlePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  cmdKindT     cmdKind,
    input  dirT         cmdDir,
    input  logic [7:0]  cmdValue,
    output logic [15:0] playerInstruction,
    output logic        isMove
);

    opcodeT     opcode;
    logic [7:0] argument;

    // request kind to opcode and argument
    always_comb begin
        opcode   = OP_NOP;
        argument = '0;
        case (cmdKind)
            CMD_MOVE: begin
                opcode   = OP_MOV;
                argument = cmdDir;
            end
            CMD_HURT: begin
                opcode   = OP_DPY;
                argument = cmdValue;
            end
            CMD_HEAL: begin
                opcode   = OP_HPY;
                argument = 8'(`HEAL_AMOUNT);
            end
            CMD_SETHP: begin
                opcode   = OP_SHP;
                argument = cmdValue;
            end
            default: begin
                opcode   = OP_NOP;
                argument = '0;
            end
        endcase
    end

    // loads every cycle so an idle request leaves an all-zero word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            playerInstruction <= '0;
            isMove            <= 1'b0;
        end else begin
            playerInstruction <= {opcode, argument, 4'h0};
            isMove            <= (cmdKind == CMD_MOVE);
        end
    end

    moveMatchesOpcode: assert property (@(posedge clk) disable iff (!rstN)
        isMove |-> (playerInstruction[15:12] == OP_MOV));

endmodule

/* hw/monsterDamage.sv */
`timescale 1ns/100ps
`include "battleCfg.svh"

module monsterDamage (
    input  logic       clk,
    input  logic       rstN,
    input  logic       hpClear,
    input  logic       hpAdd,
    input  logic [7:0] dmgMon,
    output logic [7:0] monHP,
    output logic       wouldDefeat
);

    logic [8:0] sum;

    // one extra bit catches the carry
    assign sum = {1'b0, monHP} + {1'b0, dmgMon};

    // total after this hit, seen before it lands
    assign wouldDefeat = (sum >= 9'(`KILL_HP));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            monHP <= '0;
        end else if (hpClear) begin
            monHP <= '0;
        end else if (hpAdd) begin
            if (sum[8]) begin
                monHP <= 8'hFF;
            end else begin
                monHP <= sum[7:0];
            end
        end
    end

endmodule

/* hw/battleTop.sv */
`timescale 1ns/100ps

module battleTop import battlePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [7:0]  keyboard,
    input  logic        isDeath,
    input  logic        isDmgComplete,
    input  logic        heal,
    input  logic [7:0]  damage,
    input  logic        atkPass,
    input  logic [7:0]  dmgMon,
    output pageT        page,
    output logic [15:0] playerInstruction,
    output logic        isMove,
    output logic [7:0]  monHP,
    output logic        startDmg,
    output logic        atkStart,
    output logic        atkButton,
    output logic        atkReset,
    output logic        bulletRun
);

    keyT        key;
    logic       keyPress;
    logic       pageEntry;
    logic [3:0] seconds;
    cmdKindT    cmdKind;
    dirT        cmdDir;
    logic [7:0] cmdValue;
    logic       hpClear;
    logic       hpAdd;
    logic       wouldDefeat;

    ////////////////////
    // input side
    ////////////////////
    keyDecoder keyDecoder_inst (
        .clk      (clk),
        .rstN     (rstN),
        .keyboard (keyboard),
        .key      (key),
        .keyPress (keyPress)
    );

    secondTimer secondTimer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .pageEntry (pageEntry),
        .seconds   (seconds)
    );

    battleControl battleControl_inst (
        .clk           (clk),
        .rstN          (rstN),
        .key           (key),
        .keyPress      (keyPress),
        .seconds       (seconds),
        .isDeath       (isDeath),
        .isDmgComplete (isDmgComplete),
        .heal          (heal),
        .damage        (damage),
        .atkPass       (atkPass),
        .wouldDefeat   (wouldDefeat),
        .page          (page),
        .pageEntry     (pageEntry),
        .cmdKind       (cmdKind),
        .cmdDir        (cmdDir),
        .cmdValue      (cmdValue),
        .startDmg      (startDmg),
        .hpClear       (hpClear),
        .hpAdd         (hpAdd),
        .atkStart      (atkStart),
        .atkButton     (atkButton),
        .atkReset      (atkReset),
        .bulletRun     (bulletRun)
    );

    ////////////////////
    // output side
    ////////////////////
    playerCommand playerCommand_inst (
        .clk               (clk),
        .rstN              (rstN),
        .cmdKind           (cmdKind),
        .cmdDir            (cmdDir),
        .cmdValue          (cmdValue),
        .playerInstruction (playerInstruction),
        .isMove            (isMove)
    );

    monsterDamage monsterDamage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .hpClear     (hpClear),
        .hpAdd       (hpAdd),
        .dmgMon      (dmgMon),
        .monHP       (monHP),
        .wouldDefeat (wouldDefeat)
    );

endmodule

/* verification/tbBattle.sv */
`timescale 1ns/100ps
`include "battleCfg.svh"

module tbBattle import battlePkg::*; ();

    // twelve dodge phases worth of cycles plus slack for menus and checks
    localparam int CycleLimit = 12 * `DODGE_SECONDS * `TICK_CYCLES + 400;
    localparam int DodgeWait  = `DODGE_SECONDS * `TICK_CYCLES + 8;

    logic        clk;
    logic        rstN;
    logic [7:0]  keyboard;
    logic        isDeath;
    logic        isDmgComplete;
    logic        heal;
    logic [7:0]  damage;
    logic        atkPass;
    logic [7:0]  dmgMon;
    pageT        page;
    logic [15:0] playerInstruction;
    logic        isMove;
    logic [7:0]  monHP;
    logic        startDmg;
    logic        atkStart;
    logic        atkButton;
    logic        atkReset;
    logic        bulletRun;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errStart = 0;
    int          cycleCount = 0;
    int          rounds;
    int unsigned seedValue;
    logic [7:0]  hpModel = 8'h00;
    logic [7:0]  randValue;

    keyT moveKeys [4] = '{KEY_W, KEY_A, KEY_S, KEY_D};
    dirT moveDirs [4] = '{DIR_UP, DIR_LEFT, DIR_DOWN, DIR_RIGHT};

    battleTop battleTop_inst (
        .clk               (clk),
        .rstN              (rstN),
        .keyboard          (keyboard),
        .isDeath           (isDeath),
        .isDmgComplete     (isDmgComplete),
        .heal              (heal),
        .damage            (damage),
        .atkPass           (atkPass),
        .dmgMon            (dmgMon),
        .page              (page),
        .playerInstruction (playerInstruction),
        .isMove            (isMove),
        .monHP             (monHP),
        .startDmg          (startDmg),
        .atkStart          (atkStart),
        .atkButton         (atkButton),
        .atkReset          (atkReset),
        .bulletRun         (bulletRun)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("Checks failed");
        $finish;
    end

    ////////////////////
    // reference model
    ////////////////////
    // opcode on top, argument in the middle, low nibble zero
    function automatic logic [15:0] expectWord(input opcodeT op, input logic [7:0] arg);
        return {op, arg, 4'h0};
    endfunction

    // make codes of the keyboard
    function automatic logic [7:0] scanOf(input keyT k);
        case (k)
            KEY_W:     return 8'h1D;
            KEY_A:     return 8'h1C;
            KEY_S:     return 8'h1B;
            KEY_D:     return 8'h23;
            KEY_J:     return 8'h3B;
            KEY_K:     return 8'h42;
            KEY_L:     return 8'h4B;
            KEY_SPACE: return 8'h29;
            default:   return 8'h00;
        endcase
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic checkPage(input string name, input pageT got, input pageT exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkWord(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkHp(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // monster total follows the scoreboard on every cycle
    always @(negedge clk) begin
        if (rstN) begin
            checkHp("monHP", monHP, hpModel);
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // key down for one sample, then released
    task automatic pressKey(input keyT k);
        keyboard = scanOf(k);
        @(posedge clk);
        #10;
        keyboard = 8'h00;
        @(posedge clk);
        #10;
    endtask

    task automatic waitPage(input pageT want, input int limit);
        int n;
        n = 0;
        while ((page !== want) && (n < limit)) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (page !== want) begin
            $display("page did not reach %s within %0d cycles", want.name(), limit);
            errors++;
        end
    endtask

    task automatic endTest(input string name);
        tests++;
        if (errors == errStart) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errStart);
        end
        errStart = errors;
    endtask

    // menu lockout, then space into the first dodge
    task automatic startGame();
        idle(`MENU_SECONDS * `TICK_CYCLES);
        pressKey(KEY_SPACE);
        hpModel = 8'h00;
        checkPage("page", page, PAGE_DODGE);
        checkFlag("bulletRun", bulletRun, 1'b1);
        checkWord("playerInstruction", playerInstruction, expectWord(OP_SHP, `START_HP));
    endtask

    task automatic attackRound();
        logic [7:0] dmg;
        logic [8:0] total;
        pageT       expPage;
        pressKey(KEY_J);
        checkPage("page", page, PAGE_ATTACK);
        checkFlag("atkStart", atkStart, 1'b1);
        checkFlag("atkReset", atkReset, 1'b0);
        pressKey(KEY_SPACE);
        checkFlag("atkButton", atkButton, 1'b1);
        dmg = 8'(20 + ($urandom % 31));
        total = {1'b0, hpModel} + {1'b0, dmg};
        expPage = (total >= `KILL_HP) ? PAGE_MENU : PAGE_DODGE;
        dmgMon = dmg;
        atkPass = 1'b1;
        @(posedge clk);
        #10;
        atkPass = 1'b0;
        hpModel = total[8] ? 8'hFF : total[7:0];
        checkPage("page", page, expPage);
        checkFlag("atkStart", atkStart, 1'b0);
        checkFlag("atkButton", atkButton, 1'b0);
        checkFlag("atkReset", atkReset, 1'b1);
        checkFlag("bulletRun", bulletRun, expPage == PAGE_DODGE);
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        seedValue = $urandom(32'h5fa5);
        rstN = 1'b0;
        keyboard = 8'h00;
        isDeath = 1'b0;
        isDmgComplete = 1'b0;
        heal = 1'b0;
        damage = 8'h00;
        atkPass = 1'b0;
        dmgMon = 8'h00;
        repeat (8) @(posedge clk);
        #10;
        rstN = 1'b1;

        checkPage("page", page, PAGE_MENU);
        checkFlag("atkReset", atkReset, 1'b1);
        checkFlag("bulletRun", bulletRun, 1'b0);
        checkFlag("atkStart", atkStart, 1'b0);
        checkFlag("atkButton", atkButton, 1'b0);
        checkFlag("isMove", isMove, 1'b0);
        checkFlag("startDmg", startDmg, 1'b0);
        checkWord("playerInstruction", playerInstruction, 16'h0000);
        // too early, lockout still running
        pressKey(KEY_SPACE);
        checkPage("page", page, PAGE_MENU);
        startGame();
        endTest("reset and menu lockout");

        for (int i = 0; i < 4; i++) begin
            pressKey(moveKeys[i]);
            checkWord("playerInstruction", playerInstruction, expectWord(OP_MOV, moveDirs[i]));
            checkFlag("isMove", isMove, 1'b1);
        end
        endTest("movement");

        randValue = 8'($urandom);
        damage = randValue;
        isDmgComplete = 1'b1;
        idle(1);
        isDmgComplete = 1'b0;
        checkWord("playerInstruction", playerInstruction, expectWord(OP_DPY, randValue));
        checkFlag("startDmg", startDmg, 1'b1);
        idle(1);
        checkFlag("startDmg", startDmg, 1'b0);
        heal = 1'b1;
        isDmgComplete = 1'b1;
        idle(1);
        isDmgComplete = 1'b0;
        heal = 1'b0;
        checkWord("playerInstruction", playerInstruction, expectWord(OP_HPY, `HEAL_AMOUNT));
        checkFlag("startDmg", startDmg, 1'b1);
        endTest("damage and heal");

        waitPage(PAGE_ACTION, DodgeWait);
        checkFlag("bulletRun", bulletRun, 1'b0);
        checkWord("playerInstruction", playerInstruction, 16'h0000);
        pressKey(KEY_L);
        checkPage("page", page, PAGE_DODGE);
        checkFlag("bulletRun", bulletRun, 1'b1);
        isDeath = 1'b1;
        idle(1);
        isDeath = 1'b0;
        checkPage("page", page, PAGE_MENU);
        checkFlag("bulletRun", bulletRun, 1'b0);
        endTest("dodge endings");

        startGame();
        rounds = 0;
        while ((hpModel < `KILL_HP) && (rounds < 8)) begin
            waitPage(PAGE_ACTION, DodgeWait);
            attackRound();
            rounds++;
        end
        checkPage("page", page, PAGE_MENU);
        endTest("attack");

        startGame();
        waitPage(PAGE_ACTION, DodgeWait);
        pressKey(KEY_K);
        checkPage("page", page, PAGE_CHECK);
        pressKey(KEY_J);
        checkPage("page", page, PAGE_CHECK);
        idle(`CHECK_SECONDS * `TICK_CYCLES);
        pressKey(KEY_J);
        checkPage("page", page, PAGE_DODGE);
        checkFlag("bulletRun", bulletRun, 1'b1);
        waitPage(PAGE_ACTION, DodgeWait);
        // spared monster, so L ends the game
        pressKey(KEY_L);
        checkPage("page", page, PAGE_MENU);
        checkFlag("bulletRun", bulletRun, 1'b0);
        endTest("mercy");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/battlePkg.sv
hw/keyDecoder.sv
hw/secondTimer.sv
hw/battleControl.sv
hw/playerCommand.sv
hw/monsterDamage.sv
hw/battleTop.sv
verification/tbBattle.sv
